/* common/axi_pkg.sv */
package axi_pkg;

    // burst and size encodings from the AXI spec
    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] size_word  = 3'b010;
    localparam logic [1:0] resp_okay  = 2'b00;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    // no wid, write interleaving is not supported
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

/* common/cache_bus_pkg.sv */
package cache_bus_pkg;

    // AXI IDs carried by each cache's transactions
    localparam logic [3:0] id_icache = 4'd0;
    localparam logic [3:0] id_dcache = 4'd1;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } cache_rd_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } cache_rd_rsp_t;

    typedef enum logic {
        fixed_icache_first = 1'b0,
        round_robin        = 1'b1
    } arb_mode_t;

endpackage

/* src/arbiter/cache_axi_arbiter.sv */
`timescale 1ns/1ps

module cache_axi_arbiter (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  cache_bus_pkg::arb_mode_t    i_mode,
    // icache read port
    input  cache_bus_pkg::cache_rd_req_t i_i_ar,
    input  logic                        i_i_arvalid,
    output logic                        o_i_arready,
    output cache_bus_pkg::cache_rd_rsp_t o_i_r,
    output logic                        o_i_rvalid,
    input  logic                        i_i_rready,
    // dcache read port
    input  cache_bus_pkg::cache_rd_req_t i_d_ar,
    input  logic                        i_d_arvalid,
    output logic                        o_d_arready,
    output cache_bus_pkg::cache_rd_rsp_t o_d_r,
    output logic                        o_d_rvalid,
    input  logic                        i_d_rready,
    // dcache write port
    input  axi_pkg::axi_aw_t            i_d_aw,
    input  logic                        i_d_awvalid,
    output logic                        o_d_awready,
    input  axi_pkg::axi_w_t             i_d_w,
    input  logic                        i_d_wvalid,
    output logic                        o_d_wready,
    output logic                        o_d_bvalid,
    input  logic                        i_d_bready,
    // AXI master side
    output axi_pkg::axi_ar_t            o_ar,
    output logic                        o_arvalid,
    input  logic                        i_arready,
    input  axi_pkg::axi_r_t             i_r,
    input  logic                        i_rvalid,
    output logic                        o_rready,
    output axi_pkg::axi_aw_t            o_aw,
    output logic                        o_awvalid,
    input  logic                        i_awready,
    output axi_pkg::axi_w_t             o_w,
    output logic                        o_wvalid,
    input  logic                        i_wready,
    input  axi_pkg::axi_b_t             i_b,
    input  logic                        i_bvalid,
    output logic                        o_bready,
    // grant pulses to the config block
    output logic                        o_grant_i,
    output logic                        o_grant_d
);

    // sel is 0 for icache and 1 for dcache
    logic sel;
    logic lock_q;
    logic lock_sel_q;
    logic rr_ptr_q;
    logic ar_hs;
    logic r_to_i;
    logic r_to_d;
    logic b_to_d;

    always_comb begin
        if (lock_q) begin
            sel = lock_sel_q;
        end else if (i_i_arvalid && i_d_arvalid) begin
            sel = (i_mode == cache_bus_pkg::round_robin) ? rr_ptr_q : 1'b0;
        end else begin
            sel = i_d_arvalid;
        end
    end

    assign o_arvalid = sel ? i_d_arvalid : i_i_arvalid;
    assign ar_hs     = o_arvalid && i_arready;

    // hold the choice while the memory is not ready
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
            rr_ptr_q   <= 1'b0;
        end else if (ar_hs) begin
            lock_q   <= 1'b0;
            rr_ptr_q <= ~sel;
        end else if (o_arvalid && !lock_q) begin
            lock_q     <= 1'b1;
            lock_sel_q <= sel;
        end
    end

    assign o_ar.id    = sel ? cache_bus_pkg::id_dcache : cache_bus_pkg::id_icache;
    assign o_ar.addr  = sel ? i_d_ar.addr : i_i_ar.addr;
    assign o_ar.len   = sel ? i_d_ar.len : i_i_ar.len;
    assign o_ar.size  = axi_pkg::size_word;
    assign o_ar.burst = axi_pkg::burst_incr;

    assign o_i_arready = i_arready && !sel;
    assign o_d_arready = i_arready && sel;
    assign o_grant_i   = ar_hs && !sel;
    assign o_grant_d   = ar_hs && sel;

    // R routing by rid
    assign r_to_i = (i_r.id == cache_bus_pkg::id_icache);
    assign r_to_d = (i_r.id == cache_bus_pkg::id_dcache);

    assign o_i_r.data = i_r.data;
    assign o_i_r.last = i_r.last;
    assign o_d_r.data = i_r.data;
    assign o_d_r.last = i_r.last;
    assign o_i_rvalid = i_rvalid && r_to_i;
    assign o_d_rvalid = i_rvalid && r_to_d;
    assign o_rready   = (r_to_i && i_i_rready) || (r_to_d && i_d_rready);

    // dcache write path
    assign o_aw.id     = cache_bus_pkg::id_dcache;
    assign o_aw.addr   = i_d_aw.addr;
    assign o_aw.len    = i_d_aw.len;
    assign o_aw.size   = axi_pkg::size_word;
    assign o_aw.burst  = axi_pkg::burst_incr;
    assign o_awvalid   = i_d_awvalid;
    assign o_d_awready = i_awready;

    assign o_w        = i_d_w;
    assign o_wvalid   = i_d_wvalid;
    assign o_d_wready = i_wready;

    assign b_to_d     = (i_b.id == cache_bus_pkg::id_dcache);
    assign o_d_bvalid = i_bvalid && b_to_d;
    assign o_bready   = i_d_bready && b_to_d;

    // the lock must keep AR steady even when the other cache raises valid
    ar_stable_a: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar.addr)
    );

endmodule

/* src/arbiter/arb_config.sv */
`timescale 1ns/1ps

module arb_config #(
    parameter int CNT_W = 16
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_cfg_we,
    input  logic [1:0]               i_cfg_addr,
    input  logic [31:0]              i_cfg_wdata,
    input  logic                     i_grant_i,
    input  logic                     i_grant_d,
    output logic [31:0]              o_cfg_rdata,
    output cache_bus_pkg::arb_mode_t o_mode
);

    logic [CNT_W-1:0] cnt_i_q;
    logic [CNT_W-1:0] cnt_d_q;
    logic             clear;

    assign clear = i_cfg_we && (i_cfg_addr == 2'd3);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mode <= cache_bus_pkg::fixed_icache_first;
        end else if (i_cfg_we && (i_cfg_addr == 2'd0)) begin
            o_mode <= cache_bus_pkg::arb_mode_t'(i_cfg_wdata[0]);
        end
    end

    // saturating counters, clear wins over a grant in the same cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_i_q <= '0;
            cnt_d_q <= '0;
        end else if (clear) begin
            cnt_i_q <= '0;
            cnt_d_q <= '0;
        end else begin
            if (i_grant_i && (cnt_i_q != '1)) begin
                cnt_i_q <= cnt_i_q + 1'b1;
            end
            if (i_grant_d && (cnt_d_q != '1)) begin
                cnt_d_q <= cnt_d_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (i_cfg_addr)
            2'd0:    o_cfg_rdata = {31'd0, o_mode};
            2'd1:    o_cfg_rdata = 32'(cnt_i_q);
            2'd2:    o_cfg_rdata = 32'(cnt_d_q);
            default: o_cfg_rdata = 32'd0;
        endcase
    end

endmodule

/* src/axi_burst_mem.sv */
`timescale 1ns/1ps

module axi_burst_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  axi_pkg::axi_ar_t i_ar,
    input  logic             i_arvalid,
    output logic             o_arready,
    output axi_pkg::axi_r_t  o_r,
    output logic             o_rvalid,
    input  logic             i_rready,
    input  axi_pkg::axi_aw_t i_aw,
    input  logic             i_awvalid,
    output logic             o_awready,
    input  axi_pkg::axi_w_t  i_w,
    input  logic             i_wvalid,
    output logic             o_wready,
    output axi_pkg::axi_b_t  o_b,
    output logic             o_bvalid,
    input  logic             i_bready
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_t;

    logic [31:0] mem [MEM_WORDS];

    logic             ar_hs;
    logic             r_hs;
    logic [IDX_W-1:0] rd_idx_q;
    logic [7:0]       rd_left_q;
    logic [3:0]       rd_id_q;
    logic [31:0]      rd_data_q;
    logic             rd_last_q;

    wr_state_t        wr_state_q;
    logic             aw_hs;
    logic             w_hs;
    logic [IDX_W-1:0] wr_idx_q;
    logic [3:0]       wr_id_q;

    // byte address to word index, wrapping at the end of storage
    function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
        word_index = IDX_W'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic logic [IDX_W-1:0] next_index(input logic [IDX_W-1:0] idx);
        next_index = (idx == IDX_W'(MEM_WORDS - 1)) ? '0 : idx + 1'b1;
    endfunction

    // read side is busy exactly while a beat is pending
    assign o_arready = !o_rvalid;
    assign ar_hs     = i_arvalid && o_arready;
    assign r_hs      = o_rvalid && i_rready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rvalid <= 1'b0;
        end else if (ar_hs) begin
            o_rvalid <= 1'b1;
        end else if (r_hs && rd_last_q) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_data_q <= mem[word_index(i_ar.addr)];
            rd_idx_q  <= next_index(word_index(i_ar.addr));
            rd_left_q <= i_ar.len;
            rd_last_q <= (i_ar.len == 8'd0);
            rd_id_q   <= i_ar.id;
        end else if (r_hs && !rd_last_q) begin
            rd_data_q <= mem[rd_idx_q];
            rd_idx_q  <= next_index(rd_idx_q);
            rd_left_q <= rd_left_q - 1'b1;
            rd_last_q <= (rd_left_q == 8'd1);
        end
    end

    assign o_r.id   = rd_id_q;
    assign o_r.data = rd_data_q;
    assign o_r.resp = axi_pkg::resp_okay;
    assign o_r.last = rd_last_q;

    // write side
    assign o_awready = (wr_state_q == wr_idle);
    assign o_wready  = (wr_state_q == wr_data);
    assign o_bvalid  = (wr_state_q == wr_resp);
    assign aw_hs     = i_awvalid && o_awready;
    assign w_hs      = i_wvalid && o_wready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_state_q <= wr_idle;
        end else begin
            case (wr_state_q)
                wr_idle: begin
                    if (aw_hs) begin
                        wr_state_q <= wr_data;
                    end
                end
                wr_data: begin
                    if (w_hs && i_w.last) begin
                        wr_state_q <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (i_bready) begin
                        wr_state_q <= wr_idle;
                    end
                end
                default: wr_state_q <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_idx_q <= word_index(i_aw.addr);
            wr_id_q  <= i_aw.id;
        end else if (w_hs) begin
            wr_idx_q <= next_index(wr_idx_q);
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            for (int b = 0; b < 4; b++) begin
                if (i_w.strb[b]) begin
                    mem[wr_idx_q][8*b +: 8] <= i_w.data[8*b +: 8];
                end
            end
        end
    end

    assign o_b.id   = wr_id_q;
    assign o_b.resp = axi_pkg::resp_okay;

    // a stalled beat must hold until the arbiter routes rready back
    r_hold_a: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_r)
    );

endmodule

/* src/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_WORDS = 256,
    parameter int CNT_W     = 16
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    // icache read port
    input  cache_bus_pkg::cache_rd_req_t i_i_ar,
    input  logic                         i_i_arvalid,
    output logic                         o_i_arready,
    output cache_bus_pkg::cache_rd_rsp_t o_i_r,
    output logic                         o_i_rvalid,
    input  logic                         i_i_rready,
    // dcache read port
    input  cache_bus_pkg::cache_rd_req_t i_d_ar,
    input  logic                         i_d_arvalid,
    output logic                         o_d_arready,
    output cache_bus_pkg::cache_rd_rsp_t o_d_r,
    output logic                         o_d_rvalid,
    input  logic                         i_d_rready,
    // dcache write port
    input  axi_pkg::axi_aw_t             i_d_aw,
    input  logic                         i_d_awvalid,
    output logic                         o_d_awready,
    input  axi_pkg::axi_w_t              i_d_w,
    input  logic                         i_d_wvalid,
    output logic                         o_d_wready,
    output logic                         o_d_bvalid,
    input  logic                         i_d_bready,
    // register port
    input  logic                         i_cfg_we,
    input  logic [1:0]                   i_cfg_addr,
    input  logic [31:0]                  i_cfg_wdata,
    output logic [31:0]                  o_cfg_rdata
);

    cache_bus_pkg::arb_mode_t mode;
    logic                     grant_i;
    logic                     grant_d;

    axi_pkg::axi_ar_t ar;
    logic             arvalid;
    logic             arready;
    axi_pkg::axi_r_t  r;
    logic             rvalid;
    logic             rready;
    axi_pkg::axi_aw_t aw;
    logic             awvalid;
    logic             awready;
    axi_pkg::axi_w_t  w;
    logic             wvalid;
    logic             wready;
    axi_pkg::axi_b_t  b;
    logic             bvalid;
    logic             bready;

    cache_axi_arbiter u_cache_axi_arbiter (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_mode      (mode),
        .i_i_ar      (i_i_ar),
        .i_i_arvalid (i_i_arvalid),
        .o_i_arready (o_i_arready),
        .o_i_r       (o_i_r),
        .o_i_rvalid  (o_i_rvalid),
        .i_i_rready  (i_i_rready),
        .i_d_ar      (i_d_ar),
        .i_d_arvalid (i_d_arvalid),
        .o_d_arready (o_d_arready),
        .o_d_r       (o_d_r),
        .o_d_rvalid  (o_d_rvalid),
        .i_d_rready  (i_d_rready),
        .i_d_aw      (i_d_aw),
        .i_d_awvalid (i_d_awvalid),
        .o_d_awready (o_d_awready),
        .i_d_w       (i_d_w),
        .i_d_wvalid  (i_d_wvalid),
        .o_d_wready  (o_d_wready),
        .o_d_bvalid  (o_d_bvalid),
        .i_d_bready  (i_d_bready),
        .o_ar        (ar),
        .o_arvalid   (arvalid),
        .i_arready   (arready),
        .i_r         (r),
        .i_rvalid    (rvalid),
        .o_rready    (rready),
        .o_aw        (aw),
        .o_awvalid   (awvalid),
        .i_awready   (awready),
        .o_w         (w),
        .o_wvalid    (wvalid),
        .i_wready    (wready),
        .i_b         (b),
        .i_bvalid    (bvalid),
        .o_bready    (bready),
        .o_grant_i   (grant_i),
        .o_grant_d   (grant_d)
    );

    arb_config #(
        .CNT_W (CNT_W)
    ) u_arb_config (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .i_grant_i   (grant_i),
        .i_grant_d   (grant_d),
        .o_cfg_rdata (o_cfg_rdata),
        .o_mode      (mode)
    );

    axi_burst_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_axi_burst_mem (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_ar      (ar),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_r       (r),
        .o_rvalid  (rvalid),
        .i_rready  (rready),
        .i_aw      (aw),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_w       (w),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_b       (b),
        .o_bvalid  (bvalid),
        .i_bready  (bready)
    );

endmodule

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int MEM_WORDS = 256;
    localparam int CNT_W     = 16;
    localparam int NUM_ROWS  = 32;

    localparam logic [2:0] op_write     = 3'd0;
    localparam logic [2:0] op_read_i    = 3'd1;
    localparam logic [2:0] op_read_d    = 3'd2;
    localparam logic [2:0] op_read_both = 3'd3;
    localparam logic [2:0] op_cfg_wr    = 3'd4;
    localparam logic [2:0] op_cfg_rd    = 3'd5;

    // addr2 is the dcache address of a paired read
    // value is a register value, or the cache expected to finish first (0 i, 1 d)
    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [31:0] addr2;
        logic [7:0]  len;
        logic [3:0]  strb;
        logic [31:0] value;
    } row_t;

    logic clk = 1'b0;
    logic i_rst_n;

    cache_bus_pkg::cache_rd_req_t i_i_ar;
    logic                         i_i_arvalid;
    logic                         o_i_arready;
    cache_bus_pkg::cache_rd_rsp_t o_i_r;
    logic                         o_i_rvalid;
    logic                         i_i_rready;
    cache_bus_pkg::cache_rd_req_t i_d_ar;
    logic                         i_d_arvalid;
    logic                         o_d_arready;
    cache_bus_pkg::cache_rd_rsp_t o_d_r;
    logic                         o_d_rvalid;
    logic                         i_d_rready;
    axi_pkg::axi_aw_t             i_d_aw;
    logic                         i_d_awvalid;
    logic                         o_d_awready;
    axi_pkg::axi_w_t              i_d_w;
    logic                         i_d_wvalid;
    logic                         o_d_wready;
    logic                         o_d_bvalid;
    logic                         i_d_bready;
    logic                         i_cfg_we;
    logic [1:0]                   i_cfg_addr;
    logic [31:0]                  i_cfg_wdata;
    logic [31:0]                  o_cfg_rdata;

    row_t        rows [NUM_ROWS];
    logic [31:0] shadow [MEM_WORDS];
    int          rd_beats [2];
    int          rd_idx [2];
    int          rd_done_cyc [2];
    logic [1:0]  rd_done;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    mem_subsys_top #(
        .MEM_WORDS (MEM_WORDS),
        .CNT_W     (CNT_W)
    ) u_mem_subsys_top (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_i_ar      (i_i_ar),
        .i_i_arvalid (i_i_arvalid),
        .o_i_arready (o_i_arready),
        .o_i_r       (o_i_r),
        .o_i_rvalid  (o_i_rvalid),
        .i_i_rready  (i_i_rready),
        .i_d_ar      (i_d_ar),
        .i_d_arvalid (i_d_arvalid),
        .o_d_arready (o_d_arready),
        .o_d_r       (o_d_r),
        .o_d_rvalid  (o_d_rvalid),
        .i_d_rready  (i_d_rready),
        .i_d_aw      (i_d_aw),
        .i_d_awvalid (i_d_awvalid),
        .o_d_awready (o_d_awready),
        .i_d_w       (i_d_w),
        .i_d_wvalid  (i_d_wvalid),
        .o_d_wready  (o_d_wready),
        .o_d_bvalid  (o_d_bvalid),
        .i_d_bready  (i_d_bready),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped after timeout");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s (actual %h, expected %h)",
                     $time, msg, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic int addr_to_word(input logic [31:0] addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic row_t make_row(input logic [2:0] op, input logic [31:0] addr,
                                      input logic [31:0] addr2, input logic [7:0] len,
                                      input logic [3:0] strb, input logic [31:0] value);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.addr2 = addr2;
        r.len   = len;
        r.strb  = strb;
        r.value = value;
        return r;
    endfunction

    task automatic load_table();
        rows[0]  = make_row(op_cfg_rd,    32'd0,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[1]  = make_row(op_cfg_rd,    32'd1,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[2]  = make_row(op_cfg_rd,    32'd2,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[3]  = make_row(op_write,     32'h100,   32'd0,     8'd7, 4'hf, 32'd0);
        rows[4]  = make_row(op_write,     32'h108,   32'd0,     8'd3, 4'h5, 32'd0);
        rows[5]  = make_row(op_write,     32'h200,   32'd0,     8'd7, 4'hf, 32'd0);
        // wraps past the last word
        rows[6]  = make_row(op_write,     32'h3f8,   32'd0,     8'd3, 4'hf, 32'd0);
        rows[7]  = make_row(op_write,     32'h20c,   32'd0,     8'd1, 4'h3, 32'd0);
        rows[8]  = make_row(op_read_i,    32'h100,   32'd0,     8'd7, 4'h0, 32'd0);
        rows[9]  = make_row(op_read_d,    32'h104,   32'd0,     8'd5, 4'h0, 32'd0);
        rows[10] = make_row(op_read_d,    32'h3f8,   32'd0,     8'd3, 4'h0, 32'd0);
        rows[11] = make_row(op_cfg_rd,    32'd1,     32'd0,     8'd0, 4'h0, 32'd1);
        rows[12] = make_row(op_cfg_rd,    32'd2,     32'd0,     8'd0, 4'h0, 32'd2);
        rows[13] = make_row(op_read_both, 32'h200,   32'h100,   8'd7, 4'h0, 32'd0);
        rows[14] = make_row(op_read_both, 32'h104,   32'h204,   8'd3, 4'h0, 32'd0);
        rows[15] = make_row(op_cfg_wr,    32'd0,     32'd0,     8'd0, 4'h0, 32'd1);
        rows[16] = make_row(op_cfg_rd,    32'd0,     32'd0,     8'd0, 4'h0, 32'd1);
        // round robin, single reads in between move the pointer
        rows[17] = make_row(op_read_both, 32'h200,   32'h100,   8'd5, 4'h0, 32'd0);
        rows[18] = make_row(op_read_i,    32'h108,   32'd0,     8'd2, 4'h0, 32'd0);
        rows[19] = make_row(op_read_both, 32'h200,   32'h100,   8'd5, 4'h0, 32'd1);
        rows[20] = make_row(op_read_d,    32'h204,   32'd0,     8'd2, 4'h0, 32'd0);
        rows[21] = make_row(op_read_both, 32'h104,   32'h204,   8'd2, 4'h0, 32'd0);
        rows[22] = make_row(op_cfg_rd,    32'd1,     32'd0,     8'd0, 4'h0, 32'd7);
        rows[23] = make_row(op_cfg_rd,    32'd2,     32'd0,     8'd0, 4'h0, 32'd8);
        rows[24] = make_row(op_cfg_wr,    32'd3,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[25] = make_row(op_cfg_rd,    32'd1,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[26] = make_row(op_cfg_rd,    32'd2,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[27] = make_row(op_read_i,    32'h10c,   32'd0,     8'd0, 4'h0, 32'd0);
        rows[28] = make_row(op_cfg_rd,    32'd1,     32'd0,     8'd0, 4'h0, 32'd1);
        rows[29] = make_row(op_cfg_rd,    32'd2,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[30] = make_row(op_cfg_wr,    32'd0,     32'd0,     8'd0, 4'h0, 32'd0);
        rows[31] = make_row(op_cfg_rd,    32'd0,     32'd0,     8'd0, 4'h0, 32'd0);
    endtask

    function automatic int run_budget();
        int total;
        total = 100;
        for (int k = 0; k < NUM_ROWS; k++) begin
            total += (int'(rows[k].len) + 1) * 4;
        end
        return total;
    endfunction

    task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
                               input logic [3:0] strb);
        int          idx;
        logic [31:0] d;
        logic [3:0]  s;
        idx = addr_to_word(addr);
        @(negedge clk);
        i_d_aw.id    = 4'd0;
        i_d_aw.addr  = addr;
        i_d_aw.len   = len;
        i_d_aw.size  = axi_pkg::size_word;
        i_d_aw.burst = axi_pkg::burst_incr;
        i_d_awvalid  = 1'b1;
        #1;
        while (!o_d_awready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        i_d_awvalid = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            d = $urandom;
            // odd beats take the inverted strobe
            s = (beat % 2 == 1 && strb != 4'hf) ? ~strb : strb;
            i_d_w.data = d;
            i_d_w.strb = s;
            i_d_w.last = (beat == int'(len));
            i_d_wvalid = 1'b1;
            #1;
            while (!o_d_wready) begin
                @(negedge clk);
                #1;
            end
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    shadow[idx][8*b +: 8] = d[8*b +: 8];
                end
            end
            idx = (idx + 1) % MEM_WORDS;
            @(negedge clk);
        end
        i_d_wvalid = 1'b0;
        i_d_bready = 1'b1;
        #1;
        while (!o_d_bvalid) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        i_d_bready = 1'b0;
    endtask

    task automatic collect_beat(input int p, input logic [31:0] data, input logic last,
                                input logic [7:0] len, input int cyc);
        string who;
        who = (p == 0) ? "icache" : "dcache";
        check(data, shadow[rd_idx[p]], $sformatf("%s data, beat %0d", who, rd_beats[p]));
        check(32'(last), 32'(rd_beats[p] == int'(len)), {who, " rlast position"});
        rd_beats[p]++;
        rd_idx[p] = (rd_idx[p] + 1) % MEM_WORDS;
        if (rd_beats[p] == int'(len) + 1) begin
            rd_done[p]     = 1'b1;
            rd_done_cyc[p] = cyc;
        end
    endtask

    task automatic read_bursts(input logic do_i, input logic [31:0] addr_i, input logic do_d,
                               input logic [31:0] addr_d, input logic [7:0] len,
                               output int first);
        logic [1:0] want;
        logic [1:0] granted;
        logic [1:0] hs;
        int         cyc;
        want           = {do_d, do_i};
        granted        = 2'b00;
        hs             = 2'b00;
        cyc            = 0;
        rd_beats[0]    = 0;
        rd_beats[1]    = 0;
        rd_idx[0]      = addr_to_word(addr_i);
        rd_idx[1]      = addr_to_word(addr_d);
        rd_done_cyc[0] = 0;
        rd_done_cyc[1] = 0;
        rd_done        = ~want;
        @(negedge clk);
        i_i_ar.addr = addr_i;
        i_i_ar.len  = len;
        i_d_ar.addr = addr_d;
        i_d_ar.len  = len;
        while (rd_done != 2'b11) begin
            i_i_arvalid = want[0] && !granted[0];
            i_d_arvalid = want[1] && !granted[1];
            i_i_rready  = ($urandom % 4) != 0;
            i_d_rready  = ($urandom % 4) != 0;
            #1;
            // first beat is due one cycle after the AR handshake
            if (hs[0]) begin
                check(32'(o_i_rvalid), 32'd1, "icache first beat not one cycle after AR");
            end
            if (hs[1]) begin
                check(32'(o_d_rvalid), 32'd1, "dcache first beat not one cycle after AR");
            end
            if (!(granted[0] && !rd_done[0])) begin
                check(32'(o_i_rvalid), 32'd0, "beat routed to icache with no open burst");
            end
            if (!(granted[1] && !rd_done[1])) begin
                check(32'(o_d_rvalid), 32'd0, "beat routed to dcache with no open burst");
            end
            if (o_i_rvalid && i_i_rready) begin
                collect_beat(0, o_i_r.data, o_i_r.last, len, cyc);
            end
            if (o_d_rvalid && i_d_rready) begin
                collect_beat(1, o_d_r.data, o_d_r.last, len, cyc);
            end
            hs[0]   = i_i_arvalid && o_i_arready;
            hs[1]   = i_d_arvalid && o_d_arready;
            granted = granted | hs;
            @(negedge clk);
            cyc++;
        end
        i_i_rready = 1'b0;
        i_d_rready = 1'b0;
        first = (rd_done_cyc[1] < rd_done_cyc[0]) ? 1 : 0;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        i_cfg_we    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(negedge clk);
        i_cfg_we = 1'b0;
    endtask

    task automatic cfg_read(input logic [1:0] addr, input logic [31:0] expected);
        @(negedge clk);
        i_cfg_addr = addr;
        #1;
        check(o_cfg_rdata, expected, $sformatf("register %0d readback", addr));
    endtask

    initial begin
        row_t row;
        int   first;
        void'($urandom(32'hce8e_dc60));
        i_rst_n     = 1'b0;
        i_i_ar      = '0;
        i_i_arvalid = 1'b0;
        i_i_rready  = 1'b0;
        i_d_ar      = '0;
        i_d_arvalid = 1'b0;
        i_d_rready  = 1'b0;
        i_d_aw      = '0;
        i_d_awvalid = 1'b0;
        i_d_w       = '0;
        i_d_wvalid  = 1'b0;
        i_d_bready  = 1'b0;
        i_cfg_we    = 1'b0;
        i_cfg_addr  = 2'd0;
        i_cfg_wdata = 32'd0;
        load_table();
        cycle_limit = run_budget();
        repeat (16) @(negedge clk);
        i_rst_n = 1'b1;
        for (int k = 0; k < NUM_ROWS; k++) begin
            row = rows[k];
            case (row.op)
                op_write:  write_burst(row.addr, row.len, row.strb);
                op_read_i: read_bursts(1'b1, row.addr, 1'b0, 32'd0, row.len, first);
                op_read_d: read_bursts(1'b0, 32'd0, 1'b1, row.addr, row.len, first);
                op_read_both: begin
                    read_bursts(1'b1, row.addr, 1'b1, row.addr2, row.len, first);
                    check(32'(first), row.value, $sformatf("first cache done, row %0d", k));
                end
                op_cfg_wr: cfg_write(row.addr[1:0], row.value);
                op_cfg_rd: cfg_read(row.addr[1:0], row.value);
                default:   check(32'(row.op), 32'd0, "unknown table operation");
            endcase
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* src.f */
common/axi_pkg.sv
common/cache_bus_pkg.sv
src/arbiter/cache_axi_arbiter.sv
src/arbiter/arb_config.sv
src/axi_burst_mem.sv
src/mem_subsys_top.sv
tests/tb_mem_subsys.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_mem_subsys
FILELIST  := src.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a listed source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
